//--- patch_dispatch_top.f
rtl/patch_pkg.sv
rtl/thread_link_if.sv
rtl/thread_queue.sv
rtl/patch_loader.sv
rtl/rt_scheduler.sv
rtl/ic_scheduler.sv
rtl/patch_dispatch_top.sv
tests/patch_dispatch_asserts.sv
tests/patch_dispatch_tb.sv

//--- Bender.yml
package:
  name: patch_dispatch

sources:
  - files:
      - rtl/patch_pkg.sv
      - rtl/thread_link_if.sv
      - rtl/thread_queue.sv
      - rtl/patch_loader.sv
      - rtl/rt_scheduler.sv
      - rtl/ic_scheduler.sv
      - rtl/patch_dispatch_top.sv
  - target: test
    files:
      - tests/patch_dispatch_asserts.sv
      - tests/patch_dispatch_tb.sv

//--- tests/patch_dispatch_tb.sv
`timescale 1ns/1ps

module patch_dispatch_tb;

    localparam int NUM_RT = 4;
    localparam int NUM_IC = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int WAIT_LIMIT = 200;
    // Rough test lengths in cycles
    localparam int LEN_RESET = 20;
    localparam int LEN_LOAD = 60;
    localparam int LEN_RETIRE = 120;
    localparam int LEN_SWITCH = 200;
    localparam int LEN_PAIR = 250;
    localparam int LEN_BACKPR = 400;
    localparam int WATCHDOG_CYCLES =
        4 * (LEN_RESET + LEN_LOAD + LEN_RETIRE + LEN_SWITCH + LEN_PAIR + LEN_BACKPR);

    logic                  clk;
    logic                  rst_n;
    logic                  load;
    logic                  load_done;
    patch_pkg::word_t      pixel_id;
    logic [NUM_RT-1:0]     rt_task_done;
    logic [NUM_RT-1:0]     rt_switch;
    patch_pkg::thread_id_t rt_switch_thread_id [NUM_RT];
    patch_pkg::word_t      rt_switch_pc [NUM_RT];
    patch_pkg::word_t      rt_switch_sp [NUM_RT];
    logic [NUM_RT-1:0]     rt_dispatch;
    patch_pkg::thread_id_t rt_thread_id;
    patch_pkg::word_t      rt_pixel_id;
    patch_pkg::word_t      rt_pc;
    patch_pkg::word_t      rt_sp;
    logic [NUM_RT-1:0]     rt_switch_ack;
    logic [NUM_IC-1:0]     ic_done;
    patch_pkg::thread_id_t ic_done_thread_id [NUM_IC];
    logic [NUM_IC-1:0]     ic_done_ack;
    logic [NUM_IC-1:0]     ic_dispatch;
    patch_pkg::thread_id_t ic_thread_id;
    logic                  patch_done;

    // Dispatch records captured by the monitor
    int                    rt_core_q [$];
    patch_pkg::thread_id_t rt_thread_q [$];
    patch_pkg::word_t      rt_pixel_q [$];
    patch_pkg::word_t      rt_pc_q [$];
    patch_pkg::word_t      rt_sp_q [$];
    int                    ic_core_q [$];
    patch_pkg::thread_id_t ic_thread_q [$];
    int                    done_seen;
    integer                seed;

    // Expected context table
    patch_pkg::word_t exp_pixel [patch_pkg::MAX_THREADS];
    patch_pkg::word_t exp_pc [patch_pkg::MAX_THREADS];
    patch_pkg::word_t exp_sp [patch_pkg::MAX_THREADS];

    patch_dispatch_top #(
        .NUM_RT(NUM_RT),
        .NUM_IC(NUM_IC),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_thread(input string name, input patch_pkg::thread_id_t got,
                                input patch_pkg::thread_id_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input patch_pkg::word_t got,
                              input patch_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic int onehot_index(input logic [7:0] bits);
        int idx;
        idx = -1;
        for (int i = 7; i >= 0; i--) begin
            if (bits[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Outputs settle before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (|rt_dispatch) begin
                rt_core_q.push_back(onehot_index(8'(rt_dispatch)));
                rt_thread_q.push_back(rt_thread_id);
                rt_pixel_q.push_back(rt_pixel_id);
                rt_pc_q.push_back(rt_pc);
                rt_sp_q.push_back(rt_sp);
            end
            if (|ic_dispatch) begin
                ic_core_q.push_back(onehot_index(8'(ic_dispatch)));
                ic_thread_q.push_back(ic_thread_id);
            end
            if (patch_done) begin
                done_seen++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog expired before the tests finished");
    end

    task automatic load_pixels(input int n, input int first_thread, input patch_pkg::word_t base,
                               input logic finish);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            load <= 1'b1;
            pixel_id <= base + i;
            exp_pixel[first_thread + i] = base + i;
            exp_pc[first_thread + i] = '0;
            exp_sp[first_thread + i] = '0;
        end
        @(posedge clk);
        load <= 1'b0;
        load_done <= finish;
        @(posedge clk);
        load_done <= 1'b0;
    endtask

    task automatic wait_rt_recs(input int n);
        int waited;
        waited = 0;
        while (rt_core_q.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for an RT dispatch");
            end
        end
    endtask

    task automatic wait_ic_recs(input int n);
        int waited;
        waited = 0;
        while (ic_core_q.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for an IC dispatch");
            end
        end
    endtask

    task automatic wait_patch_done(input int n);
        int waited;
        waited = 0;
        while (done_seen < n) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timed out waiting for patch_done");
            end
        end
        repeat (4) @(negedge clk);
        check_word("patch_done count", 32'(done_seen), 32'(n));
    endtask

    // Check one RT dispatch record against the context table
    task automatic check_rt_rec(input int rec, input int core, input int thread);
        check_word("rt_dispatch core", 32'(rt_core_q[rec]), 32'(core));
        check_thread("rt_thread_id", rt_thread_q[rec], thread);
        check_word("rt_pixel_id", rt_pixel_q[rec], exp_pixel[thread]);
        check_word("rt_pc", rt_pc_q[rec], exp_pc[thread]);
        check_word("rt_sp", rt_sp_q[rec], exp_sp[thread]);
    endtask

    task automatic task_done_pulse(input int core);
        @(posedge clk);
        rt_task_done[core] <= 1'b1;
        @(posedge clk);
        rt_task_done[core] <= 1'b0;
    endtask

    // RT core model: request held until acknowledged
    task automatic rt_switch_req(input int core, input int thread, input patch_pkg::word_t pc,
                                 input patch_pkg::word_t sp);
        int waited;
        waited = 0;
        @(posedge clk);
        rt_switch[core] <= 1'b1;
        rt_switch_thread_id[core] <= thread;
        rt_switch_pc[core] <= pc;
        rt_switch_sp[core] <= sp;
        exp_pc[thread] = pc;
        exp_sp[thread] = sp;
        @(negedge clk);
        while (!rt_switch_ack[core]) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("RT switch request was never acknowledged");
            end
            @(negedge clk);
        end
        @(posedge clk);
        rt_switch[core] <= 1'b0;
    endtask

    // IC core model: done held until acknowledged
    task automatic ic_finish(input int core, input int thread);
        int waited;
        waited = 0;
        @(posedge clk);
        ic_done[core] <= 1'b1;
        ic_done_thread_id[core] <= thread;
        @(negedge clk);
        while (!ic_done_ack[core]) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("IC done was never acknowledged");
            end
            @(negedge clk);
        end
        @(posedge clk);
        ic_done[core] <= 1'b0;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_bit("rt_dispatch", |rt_dispatch, 1'b0);
        check_bit("rt_switch_ack", |rt_switch_ack, 1'b0);
        check_bit("ic_dispatch", |ic_dispatch, 1'b0);
        check_bit("ic_done_ack", |ic_done_ack, 1'b0);
        check_bit("patch_done", patch_done, 1'b0);
    endtask

    task automatic test_load_six();
        load_pixels(6, 0, 32'h0000_1000, 1'b1);
        wait_rt_recs(4);
        for (int i = 0; i < 4; i++) begin
            check_rt_rec(i, i, i);
        end
    endtask

    task automatic test_retire_six();
        task_done_pulse(0);
        wait_rt_recs(5);
        check_rt_rec(4, 0, 4);
        task_done_pulse(1);
        wait_rt_recs(6);
        check_rt_rec(5, 1, 5);
        task_done_pulse(2);
        task_done_pulse(3);
        task_done_pulse(0);
        repeat (3) @(negedge clk);
        check_word("patch_done count", 32'(done_seen), 32'd0);
        task_done_pulse(1);
        wait_patch_done(1);
    endtask

    task automatic test_switch_resume();
        int rec;
        rec = rt_core_q.size();
        load_pixels(1, 0, 32'h0000_2000, 1'b1);
        wait_rt_recs(rec + 1);
        check_rt_rec(rec, 0, 0);
        rt_switch_req(0, 0, 32'h0000_0a40, 32'h0000_7f00);
        wait_ic_recs(1);
        check_word("ic_dispatch core", 32'(ic_core_q[0]), 32'd0);
        check_thread("ic_thread_id", ic_thread_q[0], 0);
        ic_finish(0, 0);
        wait_rt_recs(rec + 2);
        check_rt_rec(rec + 1, 0, 0);
        task_done_pulse(0);
        wait_patch_done(2);
    endtask

    task automatic test_switch_pair();
        int rec;
        logic [NUM_RT-1:0] acks;
        rec = rt_core_q.size();
        load_pixels(3, 0, 32'h0000_3000, 1'b1);
        wait_rt_recs(rec + 3);
        for (int i = 0; i < 3; i++) begin
            check_rt_rec(rec + i, i, i);
        end
        @(posedge clk);
        rt_switch[1] <= 1'b1;
        rt_switch[2] <= 1'b1;
        rt_switch_thread_id[1] <= 1;
        rt_switch_thread_id[2] <= 2;
        rt_switch_pc[1] <= 32'h0000_0110;
        rt_switch_sp[1] <= 32'h0000_8100;
        rt_switch_pc[2] <= 32'h0000_0220;
        rt_switch_sp[2] <= 32'h0000_8200;
        exp_pc[1] = 32'h0000_0110;
        exp_sp[1] = 32'h0000_8100;
        exp_pc[2] = 32'h0000_0220;
        exp_sp[2] = 32'h0000_8200;
        @(negedge clk);
        acks = rt_switch_ack;
        check_word("rt_switch_ack", 32'(acks), 32'h2);
        @(posedge clk);
        rt_switch[1] <= 1'b0;
        @(negedge clk);
        acks = rt_switch_ack;
        check_word("rt_switch_ack", 32'(acks), 32'h4);
        @(posedge clk);
        rt_switch[2] <= 1'b0;
        wait_ic_recs(3);
        check_thread("ic_thread_id", ic_thread_q[1], 1);
        check_thread("ic_thread_id", ic_thread_q[2], 2);
        check_word("ic_dispatch core", 32'(ic_core_q[1]), 32'd0);
        check_word("ic_dispatch core", 32'(ic_core_q[2]), 32'd1);
        ic_finish(0, 1);
        wait_rt_recs(rec + 4);
        check_rt_rec(rec + 3, 1, 1);
        ic_finish(1, 2);
        wait_rt_recs(rec + 5);
        check_rt_rec(rec + 4, 2, 2);
        task_done_pulse(0);
        task_done_pulse(1);
        task_done_pulse(2);
        wait_patch_done(3);
    endtask

    task automatic test_back_pressure();
        int rec;
        int hold;
        rec = rt_core_q.size();
        load_pixels(NUM_RT, 0, 32'h0000_4000, 1'b0);
        wait_rt_recs(rec + NUM_RT);
        // Every RT core busy while the queue fills
        load_pixels(QUEUE_DEPTH, NUM_RT, 32'h0000_4000 + NUM_RT, 1'b1);
        repeat (4) @(negedge clk);
        check_word("dispatch count", 32'(rt_core_q.size()), 32'(rec + NUM_RT));
        for (int j = 0; j < NUM_RT + QUEUE_DEPTH; j++) begin
            wait_rt_recs(rec + j + 1);
            check_thread("rt_thread_id", rt_thread_q[rec + j], j);
            check_word("rt_pixel_id", rt_pixel_q[rec + j], exp_pixel[j]);
            hold = $random(seed) & 3;
            repeat (hold) @(posedge clk);
            task_done_pulse(rt_core_q[rec + j]);
        end
        wait_patch_done(4);
    endtask

    initial begin
        seed = 81;
        done_seen = 0;
        rst_n = 1'b0;
        load = 1'b0;
        load_done = 1'b0;
        pixel_id = '0;
        rt_task_done = '0;
        rt_switch = '0;
        ic_done = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            rt_switch_thread_id[i] = '0;
            rt_switch_pc[i] = '0;
            rt_switch_sp[i] = '0;
        end
        for (int i = 0; i < NUM_IC; i++) begin
            ic_done_thread_id[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_load_six();
        test_retire_six();
        test_switch_resume();
        test_switch_pair();
        test_back_pressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tests/patch_dispatch_asserts.sv
`timescale 1ns/1ps

module patch_dispatch_asserts #(
    parameter int NUM_RT = 4,
    parameter int QUEUE_DEPTH = 8
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              load,
    input patch_pkg::load_state_t            load_state,
    input logic                              ready_push,
    input logic [$clog2(QUEUE_DEPTH):0]      ready_credits,
    input logic                              switch_push,
    input logic [$clog2(QUEUE_DEPTH):0]      switch_credits,
    input logic [NUM_RT-1:0]                 rt_dispatch,
    input logic                              patch_done
);

    ready_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
        ready_push |-> ready_credits != '0) else $error("ready queue push without credit");

    switch_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
        switch_push |-> switch_credits != '0) else $error("switch queue push without credit");

    // Load beat without a credit would be dropped
    load_beat_a: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> ready_credits != '0) else $error("load beat lost");

    // Resumed threads enter the ready queue only between patches
    resume_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        (ready_push && !load) |-> load_state == patch_pkg::LOAD_IDLE)
        else $error("resume pushed while loading");

    one_dispatch_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rt_dispatch)) else $error("more than one RT dispatch");

    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        patch_done |=> !patch_done) else $error("patch_done longer than one cycle");

endmodule

bind patch_dispatch_top patch_dispatch_asserts #(
    .NUM_RT(NUM_RT),
    .QUEUE_DEPTH(QUEUE_DEPTH)
) asserts0 (
    .clk(clk),
    .rst_n(rst_n),
    .load(load),
    .load_state(loader.state),
    .ready_push(ready_link.push),
    .ready_credits(ready_link.credits),
    .switch_push(switch_link.push),
    .switch_credits(switch_link.credits),
    .rt_dispatch(rt_dispatch),
    .patch_done(patch_done)
);

//--- rtl/patch_dispatch_top.sv
`timescale 1ns/1ps

module patch_dispatch_top #(
    parameter int NUM_RT = 4,
    parameter int NUM_IC = 4,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic                  load_done,
    input  patch_pkg::word_t      pixel_id,
    input  logic [NUM_RT-1:0]     rt_task_done,
    input  logic [NUM_RT-1:0]     rt_switch,
    input  patch_pkg::thread_id_t rt_switch_thread_id [NUM_RT],
    input  patch_pkg::word_t      rt_switch_pc [NUM_RT],
    input  patch_pkg::word_t      rt_switch_sp [NUM_RT],
    output logic [NUM_RT-1:0]     rt_dispatch,
    output patch_pkg::thread_id_t rt_thread_id,
    output patch_pkg::word_t      rt_pixel_id,
    output patch_pkg::word_t      rt_pc,
    output patch_pkg::word_t      rt_sp,
    output logic [NUM_RT-1:0]     rt_switch_ack,
    input  logic [NUM_IC-1:0]     ic_done,
    input  patch_pkg::thread_id_t ic_done_thread_id [NUM_IC],
    output logic [NUM_IC-1:0]     ic_done_ack,
    output logic [NUM_IC-1:0]     ic_dispatch,
    output patch_pkg::thread_id_t ic_thread_id,
    output logic                  patch_done
);

    logic                    ready_head_valid;
    patch_pkg::ready_entry_t ready_head;
    logic                    ready_pop;
    logic                    switch_head_valid;
    patch_pkg::thread_id_t   switch_head;
    logic                    switch_pop;
    logic                    resume_valid;
    patch_pkg::thread_id_t   resume_thread;
    logic                    resume_ack;
    logic                    loading;

    thread_link_if #(
        .entry_t(patch_pkg::ready_entry_t),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) ready_link ();

    thread_link_if #(
        .entry_t(patch_pkg::thread_id_t),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) switch_link ();

    patch_loader #(.QUEUE_DEPTH(QUEUE_DEPTH)) loader (
        .*,
        .link(ready_link)
    );

    thread_queue #(
        .entry_t(patch_pkg::ready_entry_t),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) ready_queue (
        .clk(clk),
        .rst_n(rst_n),
        .link(ready_link),
        .pop(ready_pop),
        .head_valid(ready_head_valid),
        .head(ready_head)
    );

    rt_scheduler #(.NUM_RT(NUM_RT), .QUEUE_DEPTH(QUEUE_DEPTH)) rt_sched (
        .*,
        .head_valid(ready_head_valid),
        .head(ready_head),
        .pop(ready_pop)
    );

    thread_queue #(
        .entry_t(patch_pkg::thread_id_t),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) switch_queue (
        .clk(clk),
        .rst_n(rst_n),
        .link(switch_link),
        .pop(switch_pop),
        .head_valid(switch_head_valid),
        .head(switch_head)
    );

    ic_scheduler #(.NUM_IC(NUM_IC)) ic_sched (
        .*,
        .head_valid(switch_head_valid),
        .head(switch_head),
        .pop(switch_pop)
    );

endmodule

//--- rtl/ic_scheduler.sv
`timescale 1ns/1ps

module ic_scheduler #(
    parameter int NUM_IC = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  head_valid,
    input  patch_pkg::thread_id_t head,
    output logic                  pop,
    output logic [NUM_IC-1:0]     ic_dispatch,
    output patch_pkg::thread_id_t ic_thread_id,
    input  logic [NUM_IC-1:0]     ic_done,
    input  patch_pkg::thread_id_t ic_done_thread_id [NUM_IC],
    output logic [NUM_IC-1:0]     ic_done_ack,
    output logic                  resume_valid,
    output patch_pkg::thread_id_t resume_thread,
    input  logic                  resume_ack
);

    logic [NUM_IC-1:0] busy;
    logic [NUM_IC-1:0] idle_first;
    logic [NUM_IC-1:0] done_first;

    assign idle_first = ~busy & (busy + 1'b1);
    assign done_first = ic_done & (~ic_done + 1'b1);

    assign pop = head_valid && !(&busy);
    assign ic_dispatch = pop ? idle_first : '0;
    assign ic_thread_id = head;

    // Finished core with the lowest index goes back to the loader
    assign resume_valid = |ic_done;
    assign ic_done_ack = resume_ack ? done_first : '0;

    always_comb begin
        resume_thread = '0;
        for (int i = 0; i < NUM_IC; i++) begin
            if (done_first[i]) begin
                resume_thread = ic_done_thread_id[i];
            end
        end
    end

    // Core stays busy until its resume is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~ic_done_ack) | ic_dispatch;
        end
    end

endmodule

//--- rtl/rt_scheduler.sv
`timescale 1ns/1ps

module rt_scheduler #(
    parameter int NUM_RT = 4,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    head_valid,
    input  patch_pkg::ready_entry_t head,
    output logic                    pop,
    input  logic [NUM_RT-1:0]       rt_task_done,
    input  logic [NUM_RT-1:0]       rt_switch,
    input  patch_pkg::thread_id_t   rt_switch_thread_id [NUM_RT],
    input  patch_pkg::word_t        rt_switch_pc [NUM_RT],
    input  patch_pkg::word_t        rt_switch_sp [NUM_RT],
    input  logic                    loading,
    output logic [NUM_RT-1:0]       rt_dispatch,
    output patch_pkg::thread_id_t   rt_thread_id,
    output patch_pkg::word_t        rt_pixel_id,
    output patch_pkg::word_t        rt_pc,
    output patch_pkg::word_t        rt_sp,
    output logic [NUM_RT-1:0]       rt_switch_ack,
    output logic                    patch_done,
    thread_link_if.producer         switch_link
);

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH) + 1;
    localparam int CNT_W = $clog2(patch_pkg::MAX_THREADS) + 1;

    logic [NUM_RT-1:0]     busy;
    logic [NUM_RT-1:0]     idle_first;
    logic [NUM_RT-1:0]     switch_first;
    logic                  fresh_go;
    logic                  switch_go;
    logic                  done_hit;
    logic [CNT_W-1:0]      fresh_cnt;
    logic [CNT_W-1:0]      done_cnt;
    logic [CNT_W-1:0]      done_inc;
    patch_pkg::thread_id_t sw_thread;
    patch_pkg::word_t      sw_pc;
    patch_pkg::word_t      sw_sp;
    patch_pkg::word_t      pixel_tab [patch_pkg::MAX_THREADS];
    patch_pkg::word_t      pc_tab [patch_pkg::MAX_THREADS];
    patch_pkg::word_t      sp_tab [patch_pkg::MAX_THREADS];

    // Isolate lowest set bit: lowest idle core, lowest switching core
    assign idle_first = ~busy & (busy + 1'b1);
    assign switch_first = rt_switch & (~rt_switch + 1'b1);

    assign pop = head_valid && !(&busy);
    assign rt_dispatch = pop ? idle_first : '0;
    assign fresh_go = pop && (head.kind == patch_pkg::FRESH);

    assign rt_thread_id = head.thread_id;
    always_comb begin
        if (head.kind == patch_pkg::FRESH) begin
            rt_pixel_id = head.pixel_id;
            rt_pc = '0;
            rt_sp = '0;
        end else begin
            rt_pixel_id = pixel_tab[head.thread_id];
            rt_pc = pc_tab[head.thread_id];
            rt_sp = sp_tab[head.thread_id];
        end
    end

    assign switch_go = (|rt_switch) && (switch_link.credits != '0);
    assign rt_switch_ack = switch_go ? switch_first : '0;
    assign switch_link.push = switch_go;
    assign switch_link.entry = sw_thread;

    always_comb begin
        sw_thread = '0;
        sw_pc = '0;
        sw_sp = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            if (switch_first[i]) begin
                sw_thread = rt_switch_thread_id[i];
                sw_pc = rt_switch_pc[i];
                sw_sp = rt_switch_sp[i];
            end
        end
    end

    always_comb begin
        done_inc = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            done_inc = done_inc + CNT_W'(rt_task_done[i]);
        end
    end

    // Empty queue check keeps undispatched fresh threads in the patch
    assign done_hit = (fresh_cnt != '0) && (done_cnt == fresh_cnt) && !loading && !head_valid;

    always_ff @(posedge clk) begin
        if (fresh_go) begin
            pixel_tab[head.thread_id] <= head.pixel_id;
        end
        if (switch_go) begin
            pc_tab[sw_thread] <= sw_pc;
            sp_tab[sw_thread] <= sw_sp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            fresh_cnt <= '0;
            done_cnt <= '0;
            patch_done <= 1'b0;
            switch_link.credits <= CREDIT_W'(QUEUE_DEPTH);
        end else begin
            busy <= (busy & ~rt_task_done & ~rt_switch_ack) | rt_dispatch;
            patch_done <= done_hit;
            if (done_hit) begin
                fresh_cnt <= '0;
                done_cnt <= '0;
            end else begin
                fresh_cnt <= fresh_cnt + CNT_W'(fresh_go);
                done_cnt <= done_cnt + done_inc;
            end
            switch_link.credits <= switch_link.credits + CREDIT_W'(switch_link.credit_return)
                                   - CREDIT_W'(switch_link.push);
        end
    end

endmodule

//--- rtl/patch_loader.sv
`timescale 1ns/1ps

module patch_loader #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic                  load_done,
    input  patch_pkg::word_t      pixel_id,
    input  logic                  resume_valid,
    input  patch_pkg::thread_id_t resume_thread,
    output logic                  resume_ack,
    output logic                  loading,
    thread_link_if.producer       link
);

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH) + 1;

    patch_pkg::load_state_t state;
    patch_pkg::load_state_t state_next;
    patch_pkg::thread_id_t  thread_cnt;
    patch_pkg::thread_id_t  fresh_thread;
    logic                   has_credit;
    logic                   fresh_push;

    assign has_credit = (link.credits != '0);
    assign loading = (state == patch_pkg::LOAD_ACTIVE);

    // First beat of a patch always gets thread 0
    assign fresh_thread = (state == patch_pkg::LOAD_IDLE) ? '0 : thread_cnt;
    assign fresh_push = load && has_credit;

    // Resumes only fill gaps between patches
    assign resume_ack = resume_valid && !load && !loading && has_credit;
    assign link.push = fresh_push || resume_ack;

    always_comb begin
        if (fresh_push) begin
            link.entry = '{kind: patch_pkg::FRESH, thread_id: fresh_thread, pixel_id: pixel_id};
        end else begin
            link.entry = '{kind: patch_pkg::RESUME, thread_id: resume_thread, pixel_id: '0};
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            patch_pkg::LOAD_IDLE: begin
                if (load) begin
                    state_next = patch_pkg::LOAD_ACTIVE;
                end
            end
            default: begin
                if (load_done) begin
                    state_next = patch_pkg::LOAD_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= patch_pkg::LOAD_IDLE;
            thread_cnt <= '0;
            link.credits <= CREDIT_W'(QUEUE_DEPTH);
        end else begin
            state <= state_next;
            if (fresh_push) begin
                thread_cnt <= fresh_thread + 1'b1;
            end else if (state == patch_pkg::LOAD_IDLE && load) begin
                thread_cnt <= '0;
            end
            link.credits <= link.credits + CREDIT_W'(link.credit_return)
                            - CREDIT_W'(link.push);
        end
    end

endmodule

//--- rtl/thread_queue.sv
`timescale 1ns/1ps

module thread_queue #(
    parameter type entry_t = logic,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst_n,
    thread_link_if.queue link,
    input  logic         pop,
    output logic         head_valid,
    output entry_t       head
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    entry_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    assign head_valid = (count != '0);
    assign head = mem[rd_ptr];
    assign do_pop = pop && head_valid;

    // Producer credits guarantee a free slot on every push
    always_ff @(posedge clk) begin
        if (link.push) begin
            mem[wr_ptr] <= link.entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            link.credit_return <= 1'b0;
        end else begin
            if (link.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({link.push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // Slot freed by the pop goes back one cycle later
            link.credit_return <= do_pop;
        end
    end

endmodule

//--- rtl/thread_link_if.sv
`timescale 1ns/1ps

interface thread_link_if #(
    parameter type entry_t = logic,
    parameter int QUEUE_DEPTH = 8
);

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH) + 1;

    logic                push;
    entry_t              entry;
    logic                credit_return;
    // One credit per free slot in the queue
    logic [CREDIT_W-1:0] credits;

    modport producer (
        output push,
        output entry,
        output credits,
        input  credit_return
    );

    modport queue (
        input  push,
        input  entry,
        output credit_return
    );

endinterface

//--- rtl/patch_pkg.sv
package patch_pkg;

    // Size of the per-thread context table
    localparam int MAX_THREADS = 32;
    localparam int THREAD_W = $clog2(MAX_THREADS);

    typedef logic [THREAD_W-1:0] thread_id_t;

    // Pixel id, pc or stack pointer
    typedef logic [31:0] word_t;

    typedef enum logic {
        FRESH,
        RESUME
    } entry_kind_t;

    // Ready queue entry, pixel_id only meaningful for FRESH
    typedef struct packed {
        entry_kind_t kind;
        thread_id_t  thread_id;
        word_t       pixel_id;
    } ready_entry_t;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_ACTIVE
    } load_state_t;

endpackage
